/* common/panelPkg.sv */
`default_nettype none

package panelPkg;

    // display geometry of the MS6205 panel
    localparam int COLUMNS = 16;
    localparam int ROWS = 10;

    // keypad layout, keys 0..35 are characters, the top four select the view
    localparam int KEY_COUNT = 40;
    localparam int CHAR_KEYS = 36;
    localparam int KEY_IRAM = 36;
    localparam int KEY_DRAM = 37;
    localparam int KEY_CIN = 38;
    localparam int KEY_COUT = 39;

    // writer queue depth, also the credits the source starts with
    localparam int CREDITS = 4;
    localparam int CREDIT_WIDTH = $clog2(CREDITS + 1);
    localparam int QUEUE_PTR_WIDTH = $clog2(CREDITS);

    localparam logic [7:0] SPACE_CODE = 8'h20;

    typedef enum logic [1:0] {
        VIEW_IRAM,
        VIEW_DRAM,
        VIEW_CIN,
        VIEW_COUT
    } viewT;

    typedef enum logic [2:0] {
        DPC_STOP,
        DPC_STEP,
        DPC_RUN,
        DPC_HALT
    } dpcStateT;

    // lowest pressed character key wins, 0 when none is down
    function automatic logic [7:0] keyToChar(input logic [KEY_COUNT-1:0] keys);
        logic [7:0] code;
        code = 8'h00;
        for (int i = CHAR_KEYS - 1; i >= 0; i--) begin
            if (keys[i]) begin
                code = (i < 10) ? 8'(8'h30 + i) : 8'(8'h41 + i - 10); // '0'..'9', 'A'..'Z'
            end
        end
        return code;
    endfunction

endpackage

`default_nettype wire

/* common/charBus.sv */
`timescale 1ns/10ps
`default_nettype none

// character path between display control and the write queue
interface charBus;

    logic       valid;   // one cycle per item
    logic [7:0] address;
    logic [7:0] data;    // already coded for the active-low data lines
    logic       credit;  // one cycle per freed queue slot

    modport source (
        output valid,
        output address,
        output data,
        input  credit
    );

    modport sink (
        input  valid,
        input  address,
        input  data,
        output credit
    );

endinterface

`default_nettype wire

/* keyboard/keyDecoder.sv */
`timescale 1ns/10ps
`default_nettype none

module keyDecoder
    import panelPkg::*;
(
    input  logic                 Clock_1ms,
    input  logic                 Rst_n,
    input  logic [KEY_COUNT-1:0] keys,
    output logic [KEY_COUNT-1:0] keysStable,
    output logic [7:0]           symbol
);

    logic [KEY_COUNT-1:0] keysSample;  // level seen on the previous clock
    logic [KEY_COUNT-1:0] settled;
    logic [KEY_COUNT-1:0] nextStable;

    // a bit may only move once the pin agrees with its last sample
    always_comb begin
        settled = ~(keys ^ keysSample);
        nextStable = (keys & settled) | (keysStable & ~settled);
    end

    always_ff @(posedge Clock_1ms or negedge Rst_n) begin
        if (!Rst_n) begin
            keysSample <= '0;
        end else begin
            keysSample <= keys;
        end
    end

    always_ff @(posedge Clock_1ms or negedge Rst_n) begin
        if (!Rst_n) begin
            keysStable <= '0;
            symbol <= 8'h00;
        end else begin
            keysStable <= nextStable;
            symbol <= keyToChar(nextStable);  // stays aligned with keysStable
        end
    end

endmodule

`default_nettype wire

/* ms6205/ms6205.sv */
`timescale 1ns/10ps
`default_nettype none

module ms6205
    import panelPkg::*;
(
    input  logic                 Clock_1ms,
    input  logic                 Rst_n,
    input  logic [7:0]           ipAddress,
    input  logic [7:0]           symbol,
    input  logic [KEY_COUNT-1:0] keysStable,
    input  dpcStateT             dpcState,
    output viewT                 currentView,
    output logic                 marker,
    charBus.source               charOut
);

    viewT                    nextView;
    logic [7:0]              candidate;
    logic [7:0]              lastAddress;
    logic [7:0]              lastChar;
    logic [CREDIT_WIDTH-1:0] creditCount;
    logic                    changed;
    logic                    send;

    // every cell has to be reachable over the 8-bit address lines
    if (COLUMNS * ROWS > 256) begin : gGeometry
        $error("screen geometry exceeds the 8-bit display address");
    end

    always_comb begin
        if (keysStable[KEY_IRAM]) begin
            nextView = VIEW_IRAM;
        end else if (keysStable[KEY_DRAM]) begin
            nextView = VIEW_DRAM;
        end else if (keysStable[KEY_CIN]) begin
            nextView = VIEW_CIN;
        end else if (keysStable[KEY_COUT]) begin
            nextView = VIEW_COUT;
        end else begin
            nextView = currentView;  // no view key, keep what is shown
        end
    end

    always_ff @(posedge Clock_1ms or negedge Rst_n) begin
        if (!Rst_n) begin
            currentView <= VIEW_IRAM;
        end else begin
            currentView <= nextView;
        end
    end

    // cursor only makes sense over program memory while running
    assign marker = (currentView == VIEW_IRAM) && (dpcState == DPC_RUN);

    assign candidate = (symbol == 8'h00) ? SPACE_CODE : symbol;
    assign changed = (ipAddress != lastAddress) || (candidate != lastChar);
    assign send = changed && (creditCount != '0);

    always_ff @(posedge Clock_1ms or negedge Rst_n) begin
        if (!Rst_n) begin
            charOut.valid <= 1'b0;
            lastAddress <= 8'h00;
            lastChar <= SPACE_CODE;
        end else begin
            charOut.valid <= send;
            if (send) begin
                lastAddress <= ipAddress;
                lastChar <= candidate;
            end
        end
    end

    always_ff @(posedge Clock_1ms) begin
        if (send) begin
            charOut.address <= ipAddress;
            charOut.data <= {1'b0, ~candidate[6:0]};  // display data lines are active low
        end
    end

    always_ff @(posedge Clock_1ms or negedge Rst_n) begin
        if (!Rst_n) begin
            creditCount <= CREDIT_WIDTH'(CREDITS);
        end else begin
            case ({send, charOut.credit})
                2'b10: creditCount <= creditCount - 1'b1;
                2'b01: creditCount <= creditCount + 1'b1;
                default: creditCount <= creditCount;  // spent and returned together
            endcase
        end
    end

    // returned credits must match what the writer queue can hold
    creditBound: assert property (
        @(posedge Clock_1ms) disable iff (!Rst_n)
        creditCount <= CREDIT_WIDTH'(CREDITS)
    ) else $error("credit counter above queue depth");

endmodule

`default_nettype wire

/* ms6205/ms6205Writer.sv */
`timescale 1ns/10ps
`default_nettype none

module ms6205Writer
    import panelPkg::*;
(
    input  logic       Clock_1ms,
    input  logic       Rst_n,
    charBus.sink       charIn,
    input  logic       ready,
    output logic [7:0] address,
    output logic [7:0] data,
    output logic       writeAddr,
    output logic       writeData
);

    typedef enum logic [1:0] {
        WR_IDLE,
        WR_ADDR,
        WR_DATA,
        WR_WAIT
    } wrStateT;

    wrStateT state;

    logic [7:0]                 queueAddr [CREDITS];
    logic [7:0]                 queueData [CREDITS];
    logic [QUEUE_PTR_WIDTH-1:0] wrPtr;
    logic [QUEUE_PTR_WIDTH-1:0] rdPtr;
    logic [CREDIT_WIDTH-1:0]    count;
    logic                       push;
    logic                       pop;

    assign push = charIn.valid;
    assign pop = (state == WR_IDLE) && (count != '0);

    always_ff @(posedge Clock_1ms) begin
        if (push) begin
            queueAddr[wrPtr] <= charIn.address;
            queueData[wrPtr] <= charIn.data;
        end
    end

    always_ff @(posedge Clock_1ms or negedge Rst_n) begin
        if (!Rst_n) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end else begin
            if (push) begin
                wrPtr <= wrPtr + 1'b1;  // depth is a power of two, wraps by itself
            end
            if (pop) begin
                rdPtr <= rdPtr + 1'b1;
            end
            count <= count + CREDIT_WIDTH'(push) - CREDIT_WIDTH'(pop);
        end
    end

    // address and data are loaded together and held through both strobes
    always_ff @(posedge Clock_1ms) begin
        if (pop) begin
            address <= queueAddr[rdPtr];
            data <= queueData[rdPtr];
        end
    end

    always_ff @(posedge Clock_1ms or negedge Rst_n) begin
        if (!Rst_n) begin
            state <= WR_IDLE;
            writeAddr <= 1'b0;
            writeData <= 1'b0;
            charIn.credit <= 1'b0;
        end else begin
            charIn.credit <= pop;  // slot is free as soon as the item leaves
            case (state)
                WR_IDLE: begin
                    if (pop) begin
                        writeAddr <= 1'b1;
                        state <= WR_ADDR;
                    end
                end
                WR_ADDR: begin
                    writeAddr <= 1'b0;
                    writeData <= 1'b1;
                    state <= WR_DATA;
                end
                WR_DATA: begin
                    writeData <= 1'b0;
                    state <= WR_WAIT;
                end
                default: begin
                    // display busy with the character, hold off the next one
                    if (ready) begin
                        state <= WR_IDLE;
                    end
                end
            endcase
        end
    end

    noOverflow: assert property (
        @(posedge Clock_1ms) disable iff (!Rst_n)
        push |-> count < CREDIT_WIDTH'(CREDITS)
    ) else $error("write queue overflow");

    strobesExclusive: assert property (
        @(posedge Clock_1ms) disable iff (!Rst_n)
        !(writeAddr && writeData)
    ) else $error("address and data strobes overlap");

endmodule

`default_nettype wire

/* logic/frontPanel.sv */
`timescale 1ns/10ps
`default_nettype none

module frontPanel
    import panelPkg::*;
(
    input  logic                 Clock_1ms,
    input  logic                 Rst_n,
    input  logic [KEY_COUNT-1:0] keys,
    input  logic [7:0]           ipAddress,
    input  logic [2:0]           dpcState,
    input  logic                 ready,
    output logic [7:0]           address,
    output logic [7:0]           data,
    output logic                 writeAddr,
    output logic                 writeData,
    output logic                 marker,
    output logic [1:0]           currentView
);

    logic [KEY_COUNT-1:0] keysStable;
    logic [7:0]           symbol;
    dpcStateT             dpcStateE;

    charBus charLink ();

    assign dpcStateE = dpcStateT'(dpcState);  // raw processor bits onto the state type

    keyDecoder decoder0 (
        .Clock_1ms  (Clock_1ms),
        .Rst_n      (Rst_n),
        .keys       (keys),
        .keysStable (keysStable),
        .symbol     (symbol)
    );

    ms6205 display0 (
        .Clock_1ms   (Clock_1ms),
        .Rst_n       (Rst_n),
        .ipAddress   (ipAddress),
        .symbol      (symbol),
        .keysStable  (keysStable),
        .dpcState    (dpcStateE),
        .currentView (currentView),
        .marker      (marker),
        .charOut     (charLink.source)
    );

    ms6205Writer writer0 (
        .Clock_1ms (Clock_1ms),
        .Rst_n     (Rst_n),
        .charIn    (charLink.sink),
        .ready     (ready),
        .address   (address),
        .data      (data),
        .writeAddr (writeAddr),
        .writeData (writeData)
    );

endmodule

`default_nettype wire

/* sim/tbClock.sv */
`timescale 1ns/10ps
`default_nettype none

module tbClock (
    output logic Clock_1ms,
    output logic Rst_n
);

    initial begin
        Clock_1ms = 1'b0;
        forever #5 Clock_1ms = ~Clock_1ms;  // 10 ns period
    end

    // reset held over the first four rising edges
    initial begin
        Rst_n = 1'b0;
        repeat (4) @(posedge Clock_1ms);
        #1 Rst_n = 1'b1;
    end

endmodule

`default_nettype wire

/* sim/tbFrontPanel.sv */
`timescale 1ns/10ps
`default_nettype none

module tbFrontPanel
    import panelPkg::*;
();

    localparam int RANDOM_ITEMS = 12;
    localparam int BURST_STEPS = 12;
    localparam int TEST_COUNT = 2 * RANDOM_ITEMS + BURST_STEPS + 20;
    localparam int WRITE_TIMEOUT = 40;
    localparam int VIEW_SETTLE = 4;  // two debounce edges, one view edge, one spare

    logic                 Clock_1ms;
    logic                 Rst_n;
    logic [KEY_COUNT-1:0] keys;
    logic [7:0]           ipAddress;
    logic [2:0]           dpcState;
    logic                 ready;
    logic [7:0]           address;
    logic [7:0]           data;
    logic                 writeAddr;
    logic                 writeData;
    logic                 marker;
    logic [1:0]           currentView;

    int   seed;
    int   readyDelays [64];
    logic holdReady;

    // expected values, owned by the stimulus
    logic [7:0] expAddress;
    logic [7:0] expData;
    logic       burstMode;
    bit         addrAllowed [256];
    int         stimulusErrors;
    int         expectedWrites;
    viewT       modelView;

    // observed values, owned by the comparing process
    int         writeAddrCount = 0;
    int         writeDataCount = 0;
    int         compareErrors = 0;
    logic       prevWriteAddr = 1'b0;
    logic [7:0] lastAddress = 8'h00;
    logic [7:0] lastDataAddress = 8'h00;
    logic [7:0] lastData = 8'h00;

    tbClock clock0 (
        .Clock_1ms (Clock_1ms),
        .Rst_n     (Rst_n)
    );

    frontPanel dut0 (
        .Clock_1ms   (Clock_1ms),
        .Rst_n       (Rst_n),
        .keys        (keys),
        .ipAddress   (ipAddress),
        .dpcState    (dpcState),
        .ready       (ready),
        .address     (address),
        .data        (data),
        .writeAddr   (writeAddr),
        .writeData   (writeData),
        .marker      (marker),
        .currentView (currentView)
    );

    // address in the high byte, coded data in the low byte
    function automatic logic [15:0] expectedWord(input logic [7:0] addr,
                                                 input logic [KEY_COUNT-1:0] held);
        logic [7:0] code;
        code = keyToChar(held);
        if (code == 8'h00) begin
            code = SPACE_CODE;
        end
        return {addr, 1'b0, ~code[6:0]};  // active-low data lines
    endfunction

    function automatic viewT expectedView(input logic [3:0] viewKeys, input viewT held);
        if (viewKeys[0]) return VIEW_IRAM;
        if (viewKeys[1]) return VIEW_DRAM;
        if (viewKeys[2]) return VIEW_CIN;
        if (viewKeys[3]) return VIEW_COUT;
        return held;
    endfunction

    task automatic nextDrive();
        @(posedge Clock_1ms);
        #1;
    endtask

    task automatic waitForWrites(input int target, input string what);
        int cycles;
        cycles = 0;
        while (writeDataCount < target && cycles < WRITE_TIMEOUT) begin
            @(posedge Clock_1ms);
            cycles++;
        end
        if (writeDataCount < target) begin
            stimulusErrors++;
            $display("no display write for %s within %0d cycles", what, WRITE_TIMEOUT);
        end
    endtask

    task automatic waitForLastAddress(input logic [7:0] target);
        int cycles;
        cycles = 0;
        while (lastDataAddress !== target && cycles < 10 * WRITE_TIMEOUT) begin
            @(posedge Clock_1ms);
            cycles++;
        end
        if (lastDataAddress !== target) begin
            stimulusErrors++;
            $display("final burst address %h never reached the display", target);
        end
    endtask

    // caller changes only the address or only the keys, so one write follows
    task automatic driveAndExpect(input logic [7:0] newAddress,
                                  input logic [KEY_COUNT-1:0] newKeys, input string what);
        logic [15:0] word;
        word = expectedWord(newAddress, newKeys);
        nextDrive();
        expAddress = word[15:8];
        expData = word[7:0];
        ipAddress = newAddress;
        keys = newKeys;
        expectedWrites++;
        waitForWrites(expectedWrites, what);
    endtask

    task automatic checkWriteCount(input string what);
        repeat (10) nextDrive();
        if (writeDataCount != expectedWrites) begin
            stimulusErrors++;
            $display("Mismatch at %0t: %0d writes after %s, expected %0d", $time,
                     writeDataCount, what, expectedWrites);
        end
    endtask

    task automatic pressViewKeys(input logic [3:0] viewKeys);
        logic [KEY_COUNT-1:0] newKeys;
        newKeys = keys;
        newKeys[KEY_COUNT-1:CHAR_KEYS] = viewKeys;
        modelView = expectedView(viewKeys, modelView);
        nextDrive();
        keys = newKeys;
        repeat (VIEW_SETTLE) nextDrive();
        if (currentView !== modelView) begin
            stimulusErrors++;
            $display("Mismatch at %0t: view %0d after view keys %b, expected %0d", $time,
                     currentView, viewKeys, modelView);
        end
    endtask

    // display ready returns a few cycles after each character
    initial begin
        int delayIndex;
        delayIndex = 0;
        ready = 1'b0;
        @(posedge Rst_n);
        forever begin
            @(posedge Clock_1ms);
            #1;
            if (writeData) begin
                ready = 1'b0;
                if (readyDelays[delayIndex] > 0) begin
                    repeat (readyDelays[delayIndex]) @(posedge Clock_1ms);
                    #1;
                end
                delayIndex = (delayIndex + 1) % 64;
                while (holdReady) begin
                    @(posedge Clock_1ms);
                    #1;
                end
                ready = 1'b1;
            end
        end
    end

    always @(negedge Clock_1ms) begin
        if (Rst_n) begin
            if (writeAddr && writeData) begin
                compareErrors++;
                $display("address and data strobes high together at %0t", $time);
            end
            if (writeAddr) begin
                writeAddrCount++;
                lastAddress = address;
                if (burstMode) begin
                    if (!addrAllowed[address]) begin
                        compareErrors++;
                        $display("Mismatch at %0t: address %h never driven in the burst",
                                 $time, address);
                    end
                end else if (address !== expAddress) begin
                    compareErrors++;
                    $display("Mismatch at %0t: address %h, expected %h", $time,
                             address, expAddress);
                end
            end
            if (writeData) begin
                writeDataCount++;
                lastDataAddress = lastAddress;
                lastData = data;
                if (!prevWriteAddr) begin
                    compareErrors++;
                    $display("data strobe at %0t without an address strobe before it", $time);
                end
                if (data !== expData) begin
                    compareErrors++;
                    $display("Mismatch at %0t: data %h for address %h, expected %h", $time,
                             data, lastAddress, expData);
                end
            end
            prevWriteAddr = writeAddr;
        end
    end

    initial begin
        logic [KEY_COUNT-1:0] newKeys;
        logic [7:0]           newAddress;
        logic [7:0]           finalAddress;
        int                   keyIndex;
        int                   lastKeyIndex;
        seed = 75;
        keys = '0;
        ipAddress = 8'h00;
        dpcState = DPC_STOP;
        holdReady = 1'b0;
        burstMode = 1'b0;
        expAddress = 8'h00;
        expData = 8'h00;
        stimulusErrors = 0;
        expectedWrites = 0;
        modelView = VIEW_IRAM;
        lastKeyIndex = -1;
        foreach (addrAllowed[i]) addrAllowed[i] = 1'b0;
        foreach (readyDelays[i]) readyDelays[i] = int'($unsigned($random(seed)) % 6);
        @(posedge Rst_n);

        // idle after reset
        nextDrive();
        if (currentView !== VIEW_IRAM || marker !== 1'b0) begin
            stimulusErrors++;
            $display("Mismatch at %0t: view %0d marker %b after reset, expected 0 and 0",
                     $time, currentView, marker);
        end
        repeat (20) nextDrive();
        if (writeAddrCount != 0 || writeDataCount != 0) begin
            stimulusErrors++;
            $display("display strobes seen while the inputs stayed idle");
        end

        // random characters, key first and then address
        for (int i = 0; i < RANDOM_ITEMS; i++) begin
            keyIndex = int'($unsigned($random(seed)) % CHAR_KEYS);
            if (keyIndex == lastKeyIndex) begin
                keyIndex = (keyIndex + 1) % CHAR_KEYS;
            end
            newKeys = '0;
            newKeys[keyIndex] = 1'b1;
            driveAndExpect(ipAddress, newKeys, "a key change");
            newAddress = 8'($random(seed));
            if (newAddress == ipAddress) begin
                newAddress = newAddress + 8'd1;
            end
            driveAndExpect(newAddress, newKeys, "an address change");
            lastKeyIndex = keyIndex;
        end
        driveAndExpect(ipAddress, '0, "a key release");
        checkWriteCount("the random characters");

        // view keys alone, then in pairs
        pressViewKeys(4'b0010);
        pressViewKeys(4'b0000);
        pressViewKeys(4'b0100);
        pressViewKeys(4'b1000);
        pressViewKeys(4'b0000);
        pressViewKeys(4'b1100);
        pressViewKeys(4'b1010);
        pressViewKeys(4'b0011);
        pressViewKeys(4'b0000);
        checkWriteCount("the view keys");

        // marker over both kinds of view and every processor state
        for (int v = 0; v < 2; v++) begin
            if (v == 0) begin
                pressViewKeys(4'b0001);
            end else begin
                pressViewKeys(4'b0010);
            end
            pressViewKeys(4'b0000);
            for (int s = 0; s < 8; s++) begin
                nextDrive();
                dpcState = 3'(s);
                #1;
                if (marker !== ((modelView == VIEW_IRAM) && (3'(s) == DPC_RUN))) begin
                    stimulusErrors++;
                    $display("Mismatch at %0t: marker %b for view %0d and state %0d",
                             $time, marker, modelView, s);
                end
            end
        end
        nextDrive();
        dpcState = DPC_STOP;

        // back-pressure, one character while the address runs on
        newKeys = '0;
        newKeys[5] = 1'b1;
        driveAndExpect(ipAddress, newKeys, "the burst setup");
        holdReady = 1'b1;
        burstMode = 1'b1;
        newAddress = ipAddress;
        for (int i = 0; i < BURST_STEPS; i++) begin
            newAddress = newAddress + 8'd17;  // no repeat within the burst
            addrAllowed[newAddress] = 1'b1;
            nextDrive();
            ipAddress = newAddress;
            nextDrive();
        end
        finalAddress = newAddress;
        repeat (20) nextDrive();
        holdReady = 1'b0;
        waitForLastAddress(finalAddress);
        repeat (30) nextDrive();
        if (lastDataAddress !== finalAddress || lastData !== expData) begin
            stimulusErrors++;
            $display("Mismatch at %0t: last write %h/%h, expected %h/%h", $time,
                     lastDataAddress, lastData, finalAddress, expData);
        end
        burstMode = 1'b0;
        expAddress = finalAddress;
        expectedWrites = writeDataCount;
        driveAndExpect(ipAddress, '0, "the release after the burst");

        // single-cycle pulses are filtered out
        nextDrive();
        keys[7] = 1'b1;
        nextDrive();
        keys = '0;
        repeat (10) nextDrive();
        keys[KEY_COUT] = 1'b1;
        nextDrive();
        keys = '0;
        repeat (VIEW_SETTLE) nextDrive();
        if (currentView !== modelView) begin
            stimulusErrors++;
            $display("Mismatch at %0t: view %0d after a short pulse, expected %0d", $time,
                     currentView, modelView);
        end
        checkWriteCount("the short key pulses");

        $display("%0d compare errors, %0d stimulus errors, %0d writes checked",
                 compareErrors, stimulusErrors, writeDataCount);
        if (compareErrors == 0 && stimulusErrors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    initial begin
        repeat (TEST_COUNT * 40) @(posedge Clock_1ms);
        $display("run timed out after %0d cycles", TEST_COUNT * 40);
        $display("TEST FAILED");
        $finish;
    end

endmodule

`default_nettype wire

/* files.f */
common/panelPkg.sv
common/charBus.sv
keyboard/keyDecoder.sv
ms6205/ms6205.sv
ms6205/ms6205Writer.sv
logic/frontPanel.sv
sim/tbClock.sv
sim/tbFrontPanel.sv

/* run.sh */
#!/usr/bin/env bash
# build and run the front panel testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
    --top-module tbFrontPanel \
    -f files.f \
    -Mdir obj_dir \
    -o simFrontPanel

./obj_dir/simFrontPanel | tee sim.log

if grep -qx "TEST OK" sim.log; then
    exit 0
else
    echo "simulation did not pass, see sim.log"
    exit 1
fi
